// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module CpuTb -f verilog.f -o CpuTb

run: compile
	@out="$$(./obj_dir/CpuTb)"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// ==== source/Cpu.sv ====
// Three-stage pipelined core
module Cpu #(
    parameter logic [31:0] ResetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arstN,
    output logic [31:0] instrAddr,
    input  logic [31:0] instrData,
    output logic [31:0] busAddr,
    output logic [31:0] busWData,
    output logic        busWe,
    input  logic [31:0] busRData
);

    logic                        fetchValid;
    logic [31:0]                 fetchInstr;
    logic [31:0]                 fetchPc;
    logic                        branchTaken;
    logic [31:0]                 branchTarget;
    logic [cpuPkg::RegAddrW-1:0] rAddr1;
    logic [cpuPkg::RegAddrW-1:0] rAddr2;
    logic [31:0]                 rData1;
    logic [31:0]                 rData2;
    logic [31:0]                 wbValue;
    logic                        regWe;
    logic [cpuPkg::RegAddrW-1:0] regWAddr;
    logic [31:0]                 regWData;

    exWbIf exWb ();

    StageIF #(.ResetPc(ResetPc)) StageIF_i (
        .clk(clk), .arstN(arstN),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .instrAddr(instrAddr), .instrData(instrData),
        .fetchValid(fetchValid), .fetchInstr(fetchInstr), .fetchPc(fetchPc)
    );

    StageEX StageEX_i (
        .clk(clk), .arstN(arstN),
        .fetchValid(fetchValid), .fetchInstr(fetchInstr), .fetchPc(fetchPc),
        .rAddr1(rAddr1), .rAddr2(rAddr2), .rData1(rData1), .rData2(rData2),
        .wbValue(wbValue),
        .branchTaken(branchTaken), .branchTarget(branchTarget),
        .exOut(exWb.ex), .exFwd(exWb.fwd)
    );

    StageWB StageWB_i (
        .wbIn(exWb.wb),
        .busAddr(busAddr), .busWData(busWData), .busWe(busWe), .busRData(busRData),
        .wbValue(wbValue),
        .regWe(regWe), .regWAddr(regWAddr), .regWData(regWData)
    );

    GRF GRF_i (
        .clk(clk), .arstN(arstN),
        .rAddr1(rAddr1), .rAddr2(rAddr2), .rData1(rData1), .rData2(rData2),
        .regWe(regWe), .regWAddr(regWAddr), .regWData(regWData)
    );

endmodule

// ==== source/GRF.sv ====
// General register file
module GRF (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [cpuPkg::RegAddrW-1:0] rAddr1,
    input  logic [cpuPkg::RegAddrW-1:0] rAddr2,
    output logic [cpuPkg::DataW-1:0]    rData1,
    output logic [cpuPkg::DataW-1:0]    rData2,
    input  logic                        regWe,
    input  logic [cpuPkg::RegAddrW-1:0] regWAddr,
    input  logic [cpuPkg::DataW-1:0]    regWData
);

    // Register 0 has no storage
    logic [cpuPkg::DataW-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWe && regWAddr != '0) begin
            regs[regWAddr] <= regWData;
        end
    end

    assign rData1 = (rAddr1 == '0) ? '0 : regs[rAddr1];
    assign rData2 = (rAddr2 == '0) ? '0 : regs[rAddr2];

endmodule

// ==== source/StageEX.sv ====
// Decode and execute stage
module StageEX (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        fetchValid,
    input  logic [31:0]                 fetchInstr,
    input  logic [31:0]                 fetchPc,
    output logic [cpuPkg::RegAddrW-1:0] rAddr1,
    output logic [cpuPkg::RegAddrW-1:0] rAddr2,
    input  logic [31:0]                 rData1,
    input  logic [31:0]                 rData2,
    input  logic [31:0]                 wbValue,
    output logic                        branchTaken,
    output logic [31:0]                 branchTarget,
    exWbIf.ex                           exOut,
    exWbIf.fwd                          exFwd
);

    cpuPkg::opcodeT              opcode;
    cpuPkg::functT               funct;
    cpuPkg::aluOpT               aluOp;
    cpuPkg::wbKindT              kind;
    logic [cpuPkg::RegAddrW-1:0] destReg;
    logic [15:0]                 imm;
    logic [31:0]                 immExt;
    logic                        useImm;
    logic                        isBeq;
    logic                        wbWrites;
    logic [31:0]                 rsVal;
    logic [31:0]                 rtVal;
    logic [31:0]                 opB;
    logic [31:0]                 aluRes;

    assign opcode = cpuPkg::opcodeT'(fetchInstr[31:26]);
    assign funct  = cpuPkg::functT'(fetchInstr[5:0]);
    assign imm    = fetchInstr[15:0];
    assign rAddr1 = fetchInstr[25:21];
    assign rAddr2 = fetchInstr[20:16];

    // WB holds the only older instruction in flight
    assign wbWrites = exFwd.valid && exFwd.destReg != '0
        && (exFwd.kind == cpuPkg::WbReg || exFwd.kind == cpuPkg::WbLoad);
    assign rsVal = (wbWrites && exFwd.destReg == rAddr1) ? wbValue : rData1;
    assign rtVal = (wbWrites && exFwd.destReg == rAddr2) ? wbValue : rData2;

    always_comb begin
        aluOp   = cpuPkg::AluAdd;
        kind    = cpuPkg::WbNone;
        destReg = fetchInstr[15:11];
        immExt  = {{16{imm[15]}}, imm};
        useImm  = 1'b0;
        isBeq   = 1'b0;
        if (fetchValid) begin
            case (opcode)
                cpuPkg::OpSpecial: begin
                    kind = cpuPkg::WbReg;
                    case (funct)
                        cpuPkg::FnAddu: aluOp = cpuPkg::AluAdd;
                        cpuPkg::FnSubu: aluOp = cpuPkg::AluSub;
                        cpuPkg::FnAnd:  aluOp = cpuPkg::AluAnd;
                        cpuPkg::FnOr:   aluOp = cpuPkg::AluOr;
                        cpuPkg::FnSlt:  aluOp = cpuPkg::AluSlt;
                        default:        kind  = cpuPkg::WbNone;
                    endcase
                end
                cpuPkg::OpAddiu: begin
                    kind    = cpuPkg::WbReg;
                    destReg = rAddr2;
                    useImm  = 1'b1;
                end
                cpuPkg::OpOri: begin
                    aluOp   = cpuPkg::AluOr;
                    kind    = cpuPkg::WbReg;
                    destReg = rAddr2;
                    immExt  = {16'h0000, imm};
                    useImm  = 1'b1;
                end
                cpuPkg::OpLui: begin
                    aluOp   = cpuPkg::AluLui;
                    kind    = cpuPkg::WbReg;
                    destReg = rAddr2;
                end
                cpuPkg::OpLw: begin
                    kind    = cpuPkg::WbLoad;
                    destReg = rAddr2;
                    useImm  = 1'b1;
                end
                cpuPkg::OpSw: begin
                    kind   = cpuPkg::WbStore;
                    useImm = 1'b1;
                end
                cpuPkg::OpBeq: isBeq = 1'b1;
                default: ;
            endcase
        end
    end

    assign opB = useImm ? immExt : rtVal;

    always_comb begin
        case (aluOp)
            cpuPkg::AluSub: aluRes = rsVal - opB;
            cpuPkg::AluAnd: aluRes = rsVal & opB;
            cpuPkg::AluOr:  aluRes = rsVal | opB;
            cpuPkg::AluSlt: aluRes = {31'b0, $signed(rsVal) < $signed(opB)};
            cpuPkg::AluLui: aluRes = {imm, 16'h0000};
            default:        aluRes = rsVal + opB;
        endcase
    end

    assign branchTaken  = isBeq && (rsVal == rtVal);
    assign branchTarget = fetchPc + 32'd4 + {immExt[29:0], 2'b00};

    // EX/WB register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exOut.valid <= 1'b0;
            exOut.kind  <= cpuPkg::WbNone;
        end else begin
            exOut.valid <= fetchValid;
            exOut.kind  <= kind;
        end
    end

    always_ff @(posedge clk) begin
        exOut.destReg   <= destReg;
        exOut.result    <= aluRes;
        exOut.storeData <= rtVal;
    end

    // A taken branch comes from a real instruction and leaves a bubble behind it
    branchSquash: assert property (
        @(posedge clk) disable iff (!arstN)
        branchTaken |-> fetchValid ##1 !fetchValid
    );

endmodule

// ==== source/StageIF.sv ====
// Instruction fetch stage
module StageIF #(
    parameter logic [31:0] ResetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arstN,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    output logic [31:0] instrAddr,
    input  logic [31:0] instrData,
    output logic        fetchValid,
    output logic [31:0] fetchInstr,
    output logic [31:0] fetchPc
);

    logic [31:0] pc;

    assign instrAddr = pc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= ResetPc;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // IF/EX register, squashed behind a taken branch
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= !branchTaken;
        end
    end

    always_ff @(posedge clk) begin
        fetchInstr <= instrData;
        fetchPc    <= pc;
    end

    // Branch targets come from EX, so this covers the whole redirect path
    pcAligned: assert property (
        @(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00
    );

endmodule

// ==== source/StageWB.sv ====
// Memory access and write-back stage
module StageWB (
    exWbIf.wb                           wbIn,
    output logic [31:0]                 busAddr,
    output logic [31:0]                 busWData,
    output logic                        busWe,
    input  logic [31:0]                 busRData,
    output logic [31:0]                 wbValue,
    output logic                        regWe,
    output logic [cpuPkg::RegAddrW-1:0] regWAddr,
    output logic [31:0]                 regWData
);

    logic isLoad;

    assign isLoad = wbIn.kind == cpuPkg::WbLoad;

    // Address goes out for every kind since the bus reads combinationally
    assign busAddr  = wbIn.result;
    assign busWData = wbIn.storeData;
    assign busWe    = wbIn.valid && wbIn.kind == cpuPkg::WbStore;

    assign wbValue  = isLoad ? busRData : wbIn.result;

    assign regWe    = wbIn.valid && (isLoad || wbIn.kind == cpuPkg::WbReg);
    assign regWAddr = wbIn.destReg;
    assign regWData = wbValue;

    // Word bus with no byte lanes
    always_comb begin
        storeAligned: assert (!busWe || busAddr[1:0] == 2'b00);
    end

endmodule

// ==== source/cpuPkg.sv ====
// Core shared definitions
package cpuPkg;

    localparam int RegAddrW = 5;
    localparam int DataW = 32;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OpSpecial = 6'h00,
        OpBeq     = 6'h04,
        OpAddiu   = 6'h09,
        OpOri     = 6'h0d,
        OpLui     = 6'h0f,
        OpLw      = 6'h23,
        OpSw      = 6'h2b
    } opcodeT;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FnAddu = 6'h21,
        FnSubu = 6'h23,
        FnAnd  = 6'h24,
        FnOr   = 6'h25,
        FnSlt  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt,
        AluLui
    } aluOpT;

    // What WB does with an entry
    typedef enum logic [1:0] {
        WbNone,
        WbReg,
        WbLoad,
        WbStore
    } wbKindT;

endpackage

// ==== source/exWbIf.sv ====
// EX to WB pipeline bundle
interface exWbIf;

    logic                           valid;
    cpuPkg::wbKindT                 kind;
    logic [cpuPkg::RegAddrW-1:0]    destReg;
    // ALU value, or the address for lw and sw
    logic [cpuPkg::DataW-1:0]       result;
    logic [cpuPkg::DataW-1:0]       storeData;

    modport ex (
        output valid, kind, destReg, result, storeData
    );

    modport wb (
        input valid, kind, destReg, result, storeData
    );

    // Only what the hazard check needs
    modport fwd (
        input valid, kind, destReg
    );

endinterface

// ==== test/CpuTb.sv ====
// Pipelined core testbench
module CpuTb;

    localparam logic [31:0] ResetPc  = 32'h0000_3000;
    localparam logic [31:0] DataBase = 32'h0000_1000;
    localparam int BodyOps = 80;

    logic        clk;
    logic        arstN;
    logic [31:0] instrAddr;
    logic [31:0] instrData;
    logic [31:0] busAddr;
    logic [31:0] busWData;
    logic        busWe;
    logic [31:0] busRData;

    logic [31:0] instrMem [0:1023];
    logic [31:0] dataMem [0:255];
    logic [31:0] expStoreAddr [$];
    logic [31:0] expStoreData [$];
    logic [31:0] lfsrState;
    int          progLen;
    int          storeIdx;
    int          valueErrors;
    int          countErrors;

    Cpu #(.ResetPc(ResetPc)) Cpu_i (
        .clk(clk), .arstN(arstN),
        .instrAddr(instrAddr), .instrData(instrData),
        .busAddr(busAddr), .busWData(busWData), .busWe(busWe), .busRData(busRData)
    );

    // Both memories answer in the same cycle
    assign instrData = instrMem[instrAddr[11:2]];
    assign busRData  = dataMem[busAddr[9:2]];

    always @(posedge clk) begin
        if (busWe) begin
            dataMem[busAddr[9:2]] <= busWData;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] rand16();
        logic [31:0] v;
        v = randBits(16);
        return v[15:0];
    endfunction

    // $28 and up are kept out of the random mix
    function automatic logic [4:0] randReg();
        logic [31:0] v;
        v = randBits(5) % 32'd28;
        return v[4:0];
    endfunction

    function automatic logic [15:0] randOffset();
        logic [31:0] v;
        v = randBits(6);
        return {8'h00, v[5:0], 2'b00};
    endfunction

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ ~addr ^ 32'h6d2b_79f5;
    endfunction

    function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input logic [31:0] word);
        instrMem[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] off;
        int          top;
        progLen = 0;
        for (int i = 0; i < 1024; i++) begin
            instrMem[i] = '0;
        end
        for (int r = 1; r < 28; r++) begin
            emit(iType(cpuPkg::OpLui, 5'd0, 5'(r), rand16()));
            emit(iType(cpuPkg::OpOri, 5'(r), 5'(r), rand16()));
        end
        // Data base for every lw and sw
        emit(iType(cpuPkg::OpLui, 5'd0, 5'd28, 16'h0000));
        emit(iType(cpuPkg::OpOri, 5'd28, 5'd28, DataBase[15:0]));
        for (int n = 0; n < BodyOps; n++) begin
            v = randBits(3);
            rd = randReg();
            rs = randReg();
            rt = randReg();
            case (v[2:0])
                3'd0: emit(rType(cpuPkg::FnAddu, rd, rs, rt));
                3'd1: emit(rType(cpuPkg::FnSubu, rd, rs, rt));
                3'd2: emit(rType(cpuPkg::FnAnd, rd, rs, rt));
                3'd3: emit(rType(cpuPkg::FnOr, rd, rs, rt));
                3'd4: emit(rType(cpuPkg::FnSlt, rd, rs, rt));
                3'd5: emit(iType(cpuPkg::OpAddiu, rs, rd, rand16()));
                3'd6: begin
                    v = randBits(1);
                    if (v[0]) begin
                        emit(iType(cpuPkg::OpLui, 5'd0, rd, rand16()));
                    end else begin
                        emit(iType(cpuPkg::OpOri, rs, rd, rand16()));
                    end
                end
                default: begin
                    off = randOffset();
                    emit(iType(cpuPkg::OpSw, 5'd28, rt, off));
                    v = randBits(1);
                    if (v[0]) begin
                        off = randOffset();
                    end
                    emit(iType(cpuPkg::OpLw, 5'd28, rd, off));
                    // Load result used right away
                    emit(rType(cpuPkg::FnAddu, rs, rd, rt));
                end
            endcase
        end
        // Counted loop on $29
        v = randBits(2);
        emit(iType(cpuPkg::OpOri, 5'd0, 5'd29, 16'd2 + v[15:0]));
        rd = randReg();
        rs = randReg();
        top = progLen;
        emit(iType(cpuPkg::OpAddiu, 5'd29, 5'd29, 16'hffff));
        emit(rType(cpuPkg::FnAddu, rd, rd, rs));
        emit(iType(cpuPkg::OpSw, 5'd28, 5'd29, 16'h01f0));
        // Falls through until the count is spent, then skips the back branch
        emit(iType(cpuPkg::OpBeq, 5'd29, 5'd0, 16'd1));
        emit(iType(cpuPkg::OpBeq, 5'd0, 5'd0, 16'(top - progLen - 1)));
        // squashed on every pass that loops back
        emit(iType(cpuPkg::OpAddiu, rd, rd, 16'd1));
        for (int r = 0; r < 32; r++) begin
            emit(iType(cpuPkg::OpSw, 5'd28, 5'(r), 16'(256 + 4 * r)));
        end
        emit(iType(cpuPkg::OpBeq, 5'd0, 5'd0, 16'hffff));
    endtask

    // One instruction at a time, no pipeline
    function automatic int runReference();
        logic [31:0] regs [0:31];
        logic [31:0] mem [0:255];
        logic [31:0] pc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  dest;
        logic        writes;
        logic        stop;
        int          executed;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fillWord(DataBase + 32'(4 * i));
        end
        pc = ResetPc;
        executed = 0;
        stop = 1'b0;
        while (!stop && executed < 10000) begin
            instr = instrMem[pc[11:2]];
            a = regs[instr[25:21]];
            b = regs[instr[20:16]];
            sImm = {{16{instr[15]}}, instr[15:0]};
            dest = instr[20:16];
            writes = 1'b1;
            res = '0;
            case (cpuPkg::opcodeT'(instr[31:26]))
                cpuPkg::OpSpecial: begin
                    dest = instr[15:11];
                    case (cpuPkg::functT'(instr[5:0]))
                        cpuPkg::FnAddu: res = a + b;
                        cpuPkg::FnSubu: res = a - b;
                        cpuPkg::FnAnd:  res = a & b;
                        cpuPkg::FnOr:   res = a | b;
                        cpuPkg::FnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:        writes = 1'b0;
                    endcase
                end
                cpuPkg::OpAddiu: res = a + sImm;
                cpuPkg::OpOri:   res = a | {16'h0000, instr[15:0]};
                cpuPkg::OpLui:   res = {instr[15:0], 16'h0000};
                cpuPkg::OpLw: begin
                    addr = a + sImm;
                    res = mem[addr[9:2]];
                end
                cpuPkg::OpSw: begin
                    addr = a + sImm;
                    mem[addr[9:2]] = b;
                    expStoreAddr.push_back(addr);
                    expStoreData.push_back(b);
                    writes = 1'b0;
                end
                cpuPkg::OpBeq: begin
                    writes = 1'b0;
                    if (a == b && sImm == 32'hffff_ffff) begin
                        stop = 1'b1;
                    end else if (a == b) begin
                        pc = pc + (sImm << 2);
                    end
                end
                default: writes = 1'b0;
            endcase
            if (!stop) begin
                if (writes && dest != 5'd0) begin
                    regs[dest] = res;
                end
                pc = pc + 32'd4;
                executed++;
            end
        end
        return executed;
    endfunction

    task automatic checkPc(input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: instrAddr %h, expected %h", $time, got, expected);
            valueErrors++;
        end
    endtask

    task automatic checkStore(input int idx, input logic [31:0] gotAddr,
                              input logic [31:0] gotData, input logic [31:0] wantAddr,
                              input logic [31:0] wantData);
        if (gotAddr !== wantAddr || gotData !== wantData) begin
            $display("CHECK FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
                     $time, idx, gotData, gotAddr, wantData, wantAddr);
            valueErrors++;
        end
    endtask

    // Each bus write against the next store of the reference run
    always @(posedge clk) begin
        if (!arstN) begin
            if (busWe !== 1'b0) begin
                $display("CHECK FAILED at %0t: busWe is %b during reset", $time, busWe);
                valueErrors++;
            end
        end else if (busWe === 1'b1) begin
            if (storeIdx < expStoreAddr.size()) begin
                checkStore(storeIdx, busAddr, busWData,
                           expStoreAddr[storeIdx], expStoreData[storeIdx]);
            end else begin
                $display("Extra store of %h to %h at %0t after all expected stores",
                         busWData, busAddr, $time);
                countErrors++;
            end
            storeIdx++;
        end
    end

    initial begin
        int executed;
        int cycleLimit;
        int cycles;
        arstN = 1'b0;
        lfsrState = 32'hb93a;
        valueErrors = 0;
        countErrors = 0;
        storeIdx = 0;
        buildProgram();
        for (int i = 0; i < 256; i++) begin
            dataMem[i] <= fillWord(DataBase + 32'(4 * i));
        end
        executed = runReference();
        cycleLimit = 4 * executed + 100;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        checkPc(instrAddr, ResetPc);
        cycles = 0;
        while (storeIdx < expStoreAddr.size() && cycles < cycleLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (storeIdx < expStoreAddr.size()) begin
            $display("Timeout after %0d cycles, %0d of %0d stores never appeared",
                     cycles, expStoreAddr.size() - storeIdx, expStoreAddr.size());
            countErrors += expStoreAddr.size() - storeIdx;
        end else begin
            // Self-loop must keep the bus quiet
            repeat (20) @(negedge clk);
        end
        $display("Errors: %0d wrong values, %0d extra or missing stores",
                 valueErrors, countErrors);
        if (valueErrors == 0 && countErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/cpuPkg.sv
source/exWbIf.sv
source/StageIF.sv
source/StageEX.sv
source/StageWB.sv
source/GRF.sv
source/Cpu.sv
test/CpuTb.sv
